//--- verilog/cordic_pkg.sv
//==============================
// CORDIC sine/cosine package
// Fixed-point types, region and FSM encodings,
// request/result structs and start-vector constants
//==============================
`default_nettype none

package cordic_pkg;

    //==============================
    // Widths and iteration count
    //==============================
    localparam int FRAC_BITS = 30;                     // Q2.30 fraction bits
    localparam int N_ITER    = 16;                     // Micro-rotations per request
    localparam int ITER_BITS = 4;                      // Enough for 0..15

    typedef logic signed [FRAC_BITS+1:0] angle_t;      // Radians, Q2.30
    typedef logic signed [FRAC_BITS+1:0] coord_t;      // X/Y coordinate, Q2.30
    typedef logic [ITER_BITS-1:0]        iter_t;       // Iteration index

    //==============================
    // Start vector
    //==============================
    localparam coord_t K_INV   = 32'h26DD3B6A;         // 0.607252935, inverse CORDIC gain
    localparam coord_t Y_START = '0;                   // Rotation starts on the X axis

    // Quadrant mapping applied before the request, undone at the output
    typedef enum logic [1:0] {
        REGION_DIRECT     = 2'b00,                     // No correction
        REGION_MIRROR_PI  = 2'b01,                     // pi - a, cosine flips
        REGION_SHIFT_PI   = 2'b10,                     // a - pi, both flip
        REGION_NEG_MIRROR = 2'b11                      // -pi - a, cosine flips
    } region_e;

    typedef enum logic [1:0] {
        ROT_IDLE = 2'b00,                              // Waiting for a request
        ROT_RUN  = 2'b01,                              // Iterating
        ROT_DONE = 2'b10                               // Vector held for output stage
    } rot_state_e;

    // One captured request
    typedef struct packed {
        angle_t  angle;                                // Target angle
        logic    is_sine;                              // 1 sine, 0 cosine
        region_e region;                               // Sign correction rule
    } cordic_req_t;

    // Final rotated vector plus request tags
    typedef struct packed {
        coord_t  x;                                    // Cosine before correction
        coord_t  y;                                    // Sine before correction
        logic    is_sine;
        region_e region;
    } cordic_vec_t;

endpackage

`default_nettype wire

//--- verilog/cordic_capture.sv
//==============================
// CORDIC request capture
// Accepts a start only while the rotator is idle
// and registers the request for one-cycle hand-off
//==============================
`timescale 1ns/1ps
`default_nettype none

module cordic_capture
    import cordic_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,                         // Request strobe from outside
    input  angle_t      angle_in,
    input  logic        is_sine,
    input  region_e     region,
    input  logic        idle,                          // Rotator can take a new request
    output cordic_req_t req,
    output logic        req_valid                      // One-cycle pulse per accepted start
);

    logic accept;

    assign accept = start & idle;                      // Starts while busy are dropped

    // Handshake pulse
    always_ff @(posedge clk)
    begin
        if (rst)
            req_valid <= 1'b0;
        else
            req_valid <= accept;                       // Never two in a row, idle falls first
    end

    // Request payload
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req.angle   <= angle_in;
            req.is_sine <= is_sine;
            req.region  <= region;
        end
    end

endmodule

`default_nettype wire

//--- verilog/cordic_atan_rom.sv
//==============================
// CORDIC arctangent table
// Entry i is atan(2^-i) in Q2.30, rounded
//==============================
`timescale 1ns/1ps
`default_nettype none

module cordic_atan_rom
    import cordic_pkg::*;
(
    input  iter_t  iter,                               // Current iteration
    output angle_t atan_val                            // Elementary rotation angle
);

    always_comb
    begin
        case (iter)
            4'd0:    atan_val = 32'h3243F6A9;          // pi/4
            4'd1:    atan_val = 32'h1DAC6705;
            4'd2:    atan_val = 32'h0FADBAFD;
            4'd3:    atan_val = 32'h07F56EA7;
            4'd4:    atan_val = 32'h03FEAB77;
            4'd5:    atan_val = 32'h01FFD55C;
            4'd6:    atan_val = 32'h00FFFAAB;
            4'd7:    atan_val = 32'h007FFF55;
            4'd8:    atan_val = 32'h003FFFEB;
            4'd9:    atan_val = 32'h001FFFFD;
            4'd10:   atan_val = 32'h00100000;          // From here atan(x) rounds to x
            4'd11:   atan_val = 32'h00080000;
            4'd12:   atan_val = 32'h00040000;
            4'd13:   atan_val = 32'h00020000;
            4'd14:   atan_val = 32'h00010000;
            default: atan_val = 32'h00008000;          // Iteration 15
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/cordic_rotator.sv
//==============================
// CORDIC rotation-mode engine
// Loads the pre-scaled start vector and runs
// one micro-rotation per clock on X, Y and Z,
// steered by the sign of the residual angle
//==============================
`timescale 1ns/1ps
`default_nettype none

module cordic_rotator
    import cordic_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cordic_req_t req,                           // Captured request
    input  logic        req_valid,                     // Load strobe
    input  angle_t      atan_val,                      // ROM value for current iter
    input  logic        hold,                          // Output stage still busy
    output iter_t       iter,                          // ROM address
    output logic        idle,                          // Ready for next request
    output cordic_vec_t vec,
    output logic        vec_valid                      // One-cycle pulse, vector final
);

    localparam iter_t LAST_ITER = iter_t'(N_ITER - 1);

    rot_state_e state;
    coord_t     x_q;                                   // Running X
    coord_t     y_q;                                   // Running Y
    angle_t     z_q;                                   // Residual angle
    coord_t     x_sh;
    coord_t     y_sh;
    logic       z_neg;

    assign x_sh  = x_q >>> iter;                       // Arithmetic shift by i
    assign y_sh  = y_q >>> iter;
    assign z_neg = z_q[FRAC_BITS+1];                   // Sign of Z picks direction

    assign idle = (state == ROT_IDLE);

    //==============================
    // Control FSM
    //==============================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= ROT_IDLE;
            iter      <= '0;
            vec_valid <= 1'b0;
        end
        else
        begin
            vec_valid <= 1'b0;                         // Pulse by default
            case (state)
                ROT_IDLE:
                begin
                    iter <= '0;
                    if (req_valid)
                        state <= ROT_RUN;
                end
                ROT_RUN:
                begin
                    iter <= iter + 1'b1;
                    if (iter == LAST_ITER)
                    begin
                        state     <= ROT_DONE;
                        vec_valid <= 1'b1;             // X/Y final after this edge
                    end
                end
                ROT_DONE:
                begin
                    // Wait out the load cycle, then the acknowledge
                    if (!hold && !vec_valid)
                        state <= ROT_IDLE;
                end
                default: state <= ROT_IDLE;
            endcase
        end
    end

    //==============================
    // X/Y/Z datapath
    //==============================
    always_ff @(posedge clk)
    begin
        if (idle && req_valid)
        begin
            x_q <= K_INV;                              // Gain pre-compensated
            y_q <= Y_START;
            z_q <= req.angle;
        end
        else if (state == ROT_RUN)
        begin
            if (!z_neg)
            begin
                x_q <= x_q - y_sh;                     // Rotate counter-clockwise
                y_q <= y_q + x_sh;
                z_q <= z_q - atan_val;
            end
            else
            begin
                x_q <= x_q + y_sh;                     // Rotate clockwise
                y_q <= y_q - x_sh;
                z_q <= z_q + atan_val;
            end
        end
    end

    // Tags come straight from capture, stable until the next accept
    assign vec.x       = x_q;
    assign vec.y       = y_q;
    assign vec.is_sine = req.is_sine;
    assign vec.region  = req.region;

endmodule

`default_nettype wire

//--- verilog/cordic_result.sv
//==============================
// CORDIC output stage
// Selects sine or cosine, undoes the quadrant
// mapping and holds the value until acknowledged
//==============================
`timescale 1ns/1ps
`default_nettype none

module cordic_result
    import cordic_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cordic_vec_t vec,                           // Final vector from rotator
    input  logic        vec_valid,                     // Load strobe
    input  logic        ack,                           // Consumer took data_out
    output logic        hold,                          // Result pending, rotator waits
    output logic        ready,                         // data_out valid
    output coord_t      data_out
);

    coord_t sel_val;
    logic   negate;
    coord_t fixed_val;

    assign sel_val = vec.is_sine ? vec.y : vec.x;      // Y is sine, X is cosine

    // Mirror regions flip cosine only, the pi shift flips both
    assign negate = (vec.region == REGION_SHIFT_PI) ||
                    (!vec.is_sine && ((vec.region == REGION_MIRROR_PI) ||
                                      (vec.region == REGION_NEG_MIRROR)));

    assign fixed_val = negate ? -sel_val : sel_val;    // Two's complement negate

    // Follows ready but falls in the acknowledging cycle, frees the rotator one edge early
    assign hold = ready & ~ack;

    always_ff @(posedge clk)
    begin
        if (rst)
            ready <= 1'b0;
        else if (ready && ack)
            ready <= 1'b0;                             // Handed over
        else if (vec_valid)
            ready <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (vec_valid)
            data_out <= fixed_val;                     // Held until next vector
    end

endmodule

`default_nettype wire

//--- verilog/cordic_sincos.sv
//==============================
// CORDIC sine/cosine engine, top level
// Capture, rotate and output stages plus the
// arctangent table, one request in flight
//==============================
`timescale 1ns/1ps
`default_nettype none

module cordic_sincos
    import cordic_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,                             // Request strobe
    input  angle_t  angle_in,                          // Angle in [-pi/2, pi/2]
    input  logic    is_sine,                           // 1 sine, 0 cosine
    input  region_e region,                            // Quadrant correction
    input  logic    ack,                               // Result consumed
    output logic    ready,                             // data_out valid
    output coord_t  data_out
);

    cordic_req_t req;
    logic        req_valid;
    logic        idle;
    iter_t       iter;
    angle_t      atan_val;
    cordic_vec_t vec;
    logic        vec_valid;
    logic        hold;

    cordic_capture u_capture (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .angle_in  (angle_in),
        .is_sine   (is_sine),
        .region    (region),
        .idle      (idle),
        .req       (req),
        .req_valid (req_valid)
    );

    cordic_rotator u_rotator (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .atan_val  (atan_val),
        .hold      (hold),
        .iter      (iter),
        .idle      (idle),
        .vec       (vec),
        .vec_valid (vec_valid)
    );

    cordic_atan_rom u_atan_rom (
        .iter     (iter),
        .atan_val (atan_val)
    );

    cordic_result u_result (
        .clk       (clk),
        .rst       (rst),
        .vec       (vec),
        .vec_valid (vec_valid),
        .ack       (ack),
        .hold      (hold),
        .ready     (ready),
        .data_out  (data_out)
    );

endmodule

`default_nettype wire

//--- tests/cordic_sincos_assert.sv
//==============================
// CORDIC handshake assertions
// Bound into the engine top, checks ready/ack
// protocol and output stability
//==============================
`timescale 1ns/1ps
`default_nettype none

module cordic_sincos_assert
    import cordic_pkg::*;
(
    input wire logic   clk,
    input wire logic   rst,
    input wire logic   ready,
    input wire logic   ack,
    input wire coord_t data_out
);

    int fail_cnt = 0;                                  // Read by the testbench top at the end

    a_ready_low_after_reset: assert property (@(posedge clk) rst |=> !ready)
    else
    begin
        fail_cnt++;
        $error("ready high in the cycle after reset");
    end

    // Once up, ready only drops on an edge that samples ack
    a_ready_until_ack: assert property (@(posedge clk) disable iff (rst)
        (ready && !ack) |=> ready)
    else
    begin
        fail_cnt++;
        $error("ready dropped without ack");
    end

    a_data_stable: assert property (@(posedge clk) disable iff (rst)
        (ready && !ack) |=> $stable(data_out))
    else
    begin
        fail_cnt++;
        $error("data_out changed while ready was high and ack low");
    end

endmodule

bind cordic_sincos cordic_sincos_assert u_assert (
    .clk      (clk),
    .rst      (rst),
    .ready    (ready),
    .ack      (ack),
    .data_out (data_out)
);

`default_nettype wire

//--- tests/cordic_checker.sv
//==============================
// CORDIC result checker
// Tracks accepted requests at the DUT ports,
// computes the expected fixed-point result and
// checks value, latency and hold behaviour
//==============================
`timescale 1ns/1ps
`default_nettype none

module cordic_checker
    import cordic_pkg::*;
(
    input wire logic    clk,
    input wire logic    rst,
    input wire logic    start,
    input wire angle_t  angle_in,
    input wire logic    is_sine,
    input wire region_e region,
    input wire logic    ack,
    input wire logic    ready,
    input wire coord_t  data_out
);

    localparam int LATENCY = 18;                       // Accept edge to ready rise

    cordic_req_t pend_q[$];                            // Accepted, not yet consumed
    cordic_req_t cur;
    cordic_req_t acc;
    coord_t      exp_val;
    coord_t      held_val;                             // data_out when ready rose
    logic        busy        = 1'b0;                   // Engine owns a request
    logic        ready_q     = 1'b0;
    logic        rst_q       = 1'b0;
    int          cyc         = 0;
    int          acc_cyc     = 0;
    int          checks      = 0;
    int          errors      = 0;
    int          test_checks = 0;
    int          test_errs   = 0;
    int          n_tests     = 0;
    int          n_failed    = 0;

    // Bit-exact model: rounded atan table, K_INV start, 16 shift-add steps
    function automatic coord_t ref_value(input cordic_req_t r);
        coord_t x;
        coord_t y;
        angle_t z;
        coord_t xs;
        coord_t ys;
        angle_t at;
        coord_t sel;
        logic   neg;
        int     i;
        x = K_INV;
        y = '0;
        z = r.angle;
        for (i = 0; i < N_ITER; i++)
        begin
            at = angle_t'($rtoi($floor($atan(1.0 / (2.0 ** i)) * 1073741824.0 + 0.5)));
            xs = x >>> i;                              // Old X and Y feed both updates
            ys = y >>> i;
            if (z >= 0)
            begin
                x = x - ys;
                y = y + xs;
                z = z - at;
            end
            else
            begin
                x = x + ys;
                y = y - xs;
                z = z + at;
            end
        end
        sel = r.is_sine ? y : x;
        neg = (r.region == REGION_SHIFT_PI) ||
              (!r.is_sine && (r.region == REGION_MIRROR_PI || r.region == REGION_NEG_MIRROR));
        return neg ? -sel : sel;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        test_errs++;
        $display("%s", msg);
    endtask

    // Called by the testbench top when one test group is over
    task automatic end_test(input string name);
        n_tests++;
        if (test_checks == 0)
            flag_error($sformatf("test %s finished without any result", name));
        if (test_errs != 0)
            n_failed++;
        $display("test %-14s results %0d, errors %0d, %s", name, test_checks, test_errs,
                 (test_errs == 0) ? "ok" : "failed");
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic final_check();
        if (pend_q.size() != 0)
            flag_error($sformatf("%0d accepted requests never produced a result",
                                 pend_q.size()));
    endtask

    //==============================
    // Port monitor
    //==============================
    always @(posedge clk)
    begin
        cyc++;
        if (rst)
        begin
            pend_q.delete();                           // In-flight request is lost
            busy = 1'b0;
        end
        else
        begin
            if (rst_q && ready !== 1'b0)
                flag_error($sformatf("** Error ready: expected %h, actual %h after reset",
                                     1'b0, ready));
            if (start && !busy)                        // Start only counts when engine is free
            begin
                acc.angle   = angle_in;
                acc.is_sine = is_sine;
                acc.region  = region;
                pend_q.push_back(acc);
                busy    = 1'b1;
                acc_cyc = cyc;
            end
            if (ready && !ready_q)
            begin
                held_val = data_out;
                if (pend_q.size() == 0)
                    flag_error("ready rose with no request pending");
                else if (cyc - acc_cyc - 1 != LATENCY)
                    flag_error($sformatf("ready rose %0d edges after start, expected %0d",
                                         cyc - acc_cyc - 1, LATENCY));
            end
            else if (ready && data_out !== held_val)
                flag_error($sformatf("** Error data_out: expected %h, actual %h while held",
                                     held_val, data_out));
            if (ready && ack)                          // Consumption edge
            begin
                if (pend_q.size() != 0)
                begin
                    cur     = pend_q.pop_front();
                    exp_val = ref_value(cur);
                    checks++;
                    test_checks++;
                    if (data_out !== exp_val)
                        flag_error($sformatf(
                            "** Error data_out: expected %h, actual %h (angle %h, %s, %s)",
                            exp_val, data_out, cur.angle, cur.is_sine ? "sine" : "cosine",
                            cur.region.name()));
                end
                busy = 1'b0;
            end
        end
        ready_q = rst ? 1'b0 : ready;
        rst_q   = rst;
    end

endmodule

`default_nettype wire

//--- tests/tb_cordic_sincos.sv
//==============================
// CORDIC sine/cosine testbench
// Clock, reset, request stimulus with ack
// back-pressure, watchdog and DUT instance
//==============================
`timescale 1ns/1ps
`default_nettype none

module tb_cordic_sincos
    import cordic_pkg::*;
();

    localparam int  CLK_PERIOD    = 8;
    localparam int  SEED          = 33664;
    localparam int  N_RANDOM      = 200;
    localparam int  N_LATENCY     = 5;
    localparam int  N_BACKPRESS   = 20;
    localparam int  N_REQ         = 18 + N_RANDOM + N_LATENCY + N_BACKPRESS + 3;
    localparam int  MAX_ACK_DELAY = 20;
    localparam int  READY_LIMIT   = 40;                // Cycles to wait for ready
    localparam int  TIMEOUT_NS    = N_REQ * (18 + MAX_ACK_DELAY + 4) * CLK_PERIOD + 2000;
    localparam real PI            = 3.14159265358979;
    localparam int  HALF_PI_Q     = 32'h6487ED51;      // pi/2 in Q2.30

    logic    clk;
    logic    rst;
    logic    start;
    angle_t  angle_in;
    logic    is_sine;
    region_e region;
    logic    ack;
    logic    ready;
    coord_t  data_out;
    real     fixed_ang [9];
    int      hs_timeouts = 0;
    int      total;

    cordic_sincos u_cordic_sincos (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .angle_in (angle_in),
        .is_sine  (is_sine),
        .region   (region),
        .ack      (ack),
        .ready    (ready),
        .data_out (data_out)
    );

    cordic_checker u_checker (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .angle_in (angle_in),
        .is_sine  (is_sine),
        .region   (region),
        .ack      (ack),
        .ready    (ready),
        .data_out (data_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("watchdog expired, the run did not finish in %0d ns", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

    function automatic angle_t to_fixed(input real r);
        return angle_t'($rtoi($floor(r * 1073741824.0 + 0.5)));
    endfunction

    // Uniform in [-pi/2, pi/2]
    function automatic angle_t rand_angle();
        longint span;
        span = 2 * longint'(HALF_PI_Q) + 1;
        return angle_t'(longint'($urandom) % span - HALF_PI_Q);
    endfunction

    // One request, ack after ack_delay cycles, optional stray start while held
    // Called on a falling edge, start goes out at once so it meets the edge right after the ack edge
    task automatic run_request(input angle_t a, input logic s, input region_e r,
                               input int ack_delay, input logic poke);
        int n;
        int k;
        int poke_at;
        n       = 0;
        poke_at = (ack_delay > 0) ? int'($urandom % ack_delay) : -1;
        start    = 1'b1;
        angle_in = a;
        is_sine  = s;
        region   = r;
        @(negedge clk);
        start = 1'b0;
        while (ready !== 1'b1 && n < READY_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (ready !== 1'b1)
        begin
            hs_timeouts++;
            $display("no ready within %0d cycles of start", READY_LIMIT);
        end
        else
        begin
            for (k = 0; k < ack_delay; k++)
            begin
                start = poke && (k == poke_at);        // Must be ignored while busy
                if (start)
                    angle_in = rand_angle();
                @(negedge clk);
            end
            start = 1'b0;
            ack   = 1'b1;
            @(negedge clk);
            ack = 1'b0;
        end
    endtask

    // Start a request and reset the engine while it rotates
    task automatic abort_with_reset(input angle_t a);
        @(negedge clk);
        start    = 1'b1;
        angle_in = a;
        @(negedge clk);
        start = 1'b0;
        repeat (6) @(negedge clk);
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    //==============================
    // Test sequence
    //==============================
    initial
    begin
        void'($urandom(SEED));
        rst       = 1'b1;
        start     = 1'b0;
        angle_in  = '0;
        is_sine   = 1'b0;
        region    = REGION_DIRECT;
        ack       = 1'b0;
        fixed_ang = '{0.0, PI / 6, -PI / 6, PI / 4, -PI / 4, PI / 3, -PI / 3, PI / 2, -PI / 2};
        repeat (3) @(negedge clk);
        rst = 1'b0;

        foreach (fixed_ang[i])
        begin
            run_request(to_fixed(fixed_ang[i]), 1'b0, REGION_DIRECT, 0, 1'b0);
            run_request(to_fixed(fixed_ang[i]), 1'b1, REGION_DIRECT, 0, 1'b0);
        end
        u_checker.end_test("fixed angles");

        repeat (N_RANDOM)
            run_request(rand_angle(), 1'($urandom % 2), region_e'($urandom % 4), 0, 1'b0);
        u_checker.end_test("random angles");

        repeat (N_LATENCY)
            run_request(rand_angle(), 1'($urandom % 2), REGION_DIRECT, 0, 1'b0);
        u_checker.end_test("latency");

        repeat (N_BACKPRESS)
            run_request(rand_angle(), 1'($urandom % 2), region_e'($urandom % 4),
                        int'($urandom % (MAX_ACK_DELAY + 1)), 1'b1);
        u_checker.end_test("back-pressure");

        abort_with_reset(rand_angle());
        run_request(rand_angle(), 1'b1, REGION_DIRECT, 0, 1'b0);
        run_request(rand_angle(), 1'b0, REGION_SHIFT_PI, 3, 1'b0);
        u_checker.end_test("reset mid-run");

        u_checker.final_check();
        total = u_checker.errors + u_cordic_sincos.u_assert.fail_cnt + hs_timeouts;
        $display("results %0d, tests %0d (%0d failed), errors %0d, assertion failures %0d, %s",
                 u_checker.checks, u_checker.n_tests, u_checker.n_failed, u_checker.errors,
                 u_cordic_sincos.u_assert.fail_cnt, $sformatf("timeouts %0d", hs_timeouts));
        if (total == 0 && u_checker.checks > 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- cordic_sincos.f
verilog/cordic_pkg.sv
verilog/cordic_capture.sv
verilog/cordic_atan_rom.sv
verilog/cordic_rotator.sv
verilog/cordic_result.sv
verilog/cordic_sincos.sv
tests/cordic_sincos_assert.sv
tests/cordic_checker.sv
tests/tb_cordic_sincos.sv

//--- Bender.yml
package:
  name: cordic_sincos

sources:
  - verilog/cordic_pkg.sv
  - verilog/cordic_capture.sv
  - verilog/cordic_atan_rom.sv
  - verilog/cordic_rotator.sv
  - verilog/cordic_result.sv
  - verilog/cordic_sincos.sv
  - target: test
    files:
      - tests/cordic_sincos_assert.sv
      - tests/cordic_checker.sv
      - tests/tb_cordic_sincos.sv
